// ==== source/ik_defines.svh ====
// ======================================
// widths and register map of the ik step
// ======================================
`ifndef IK_DEFINES_SVH
`define IK_DEFINES_SVH

// fixed point q7.8
`define IK_DATA_W 16
`define IK_FRAC_W 8

// wishbone word address and data widths
`define IK_WB_AW 4
`define IK_WB_DW 32

// word addresses
`define IK_ADDR_CTRL   4'd0
`define IK_ADDR_STATUS 4'd1
`define IK_ADDR_J00    4'd2
`define IK_ADDR_J01    4'd3
`define IK_ADDR_J10    4'd4
`define IK_ADDR_J11    4'd5
`define IK_ADDR_E0     4'd6
`define IK_ADDR_E1     4'd7
`define IK_ADDR_LAMBDA 4'd8
`define IK_ADDR_DELTA0 4'd9
`define IK_ADDR_DELTA1 4'd10

`endif

// ==== source/ik_pkg.sv ====
// ======================================
// fixed-point, matrix and schedule types
// ======================================
`include "ik_defines.svh"

package ik_pkg;

	// one signed fixed-point value
	typedef logic signed [`IK_DATA_W-1:0] fixed_t;

	// 2x2 matrix, indexed [row][col]
	typedef fixed_t [1:0][1:0] mat2_t;

	// schedule of one damped least squares step
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_JJT,
		ST_INV,
		ST_SCALE,
		ST_JT_INV,
		ST_APPLY,
		ST_DONE
	} step_state_t;

	// full product, shifted down by the fraction bits, low word kept
	function automatic fixed_t fix_mul(input fixed_t a, input fixed_t b);
		logic signed [2*`IK_DATA_W-1:0] p;
		p = a * b;
		return p[`IK_FRAC_W +: `IK_DATA_W];
	endfunction

endpackage

// ==== source/wb_ik_regs.sv ====
// ======================================
// wishbone slave with the ik registers
// ======================================
`timescale 1ns/1ps
`include "ik_defines.svh"

module wb_ik_regs (
	input  logic                 i,
	input  logic                 i_reset,
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  logic [`IK_WB_AW-1:0] i_wb_adr,
	input  logic [`IK_WB_DW-1:0] i_wb_dat,
	input  logic                 i_busy,
	input  logic                 i_done,
	input  logic                 i_singular,
	input  ik_pkg::fixed_t       i_delta0,
	input  ik_pkg::fixed_t       i_delta1,
	output logic [`IK_WB_DW-1:0] o_wb_dat,
	output logic                 o_wb_ack,
	output logic                 o_start,
	output ik_pkg::mat2_t        o_jac,
	output ik_pkg::fixed_t       o_err0,
	output ik_pkg::fixed_t       o_err1,
	output ik_pkg::fixed_t       o_lambda,
	output logic                 o_irq
);
	import ik_pkg::*;

	logic                 req;
	fixed_t               wr_val;
	logic [`IK_WB_DW-1:0] rd_val;

	function automatic logic [`IK_WB_DW-1:0] sext(input fixed_t v);
		return {{(`IK_WB_DW-`IK_DATA_W){v[`IK_DATA_W-1]}}, v};
	endfunction

	// new request only while no ack is out
	assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign wr_val = i_wb_dat[`IK_DATA_W-1:0];
	assign o_irq = i_done;

	// one wait state, start pulses together with the ack
	always_ff @(posedge i) begin
		if (i_reset) begin
			o_wb_ack <= 1'b0;
			o_start <= 1'b0;
		end else begin
			o_wb_ack <= req;
			o_start <= req && i_wb_we && (i_wb_adr == `IK_ADDR_CTRL) && i_wb_dat[0];
		end
	end

	// operand registers
	always_ff @(posedge i) begin
		if (req && i_wb_we) begin
			case (i_wb_adr)
				`IK_ADDR_J00:    o_jac[0][0] <= wr_val;
				`IK_ADDR_J01:    o_jac[0][1] <= wr_val;
				`IK_ADDR_J10:    o_jac[1][0] <= wr_val;
				`IK_ADDR_J11:    o_jac[1][1] <= wr_val;
				`IK_ADDR_E0:     o_err0 <= wr_val;
				`IK_ADDR_E1:     o_err1 <= wr_val;
				`IK_ADDR_LAMBDA: o_lambda <= wr_val;
				default: ;
			endcase
		end
	end

	// read mux, control and unmapped words read zero
	always_comb begin
		case (i_wb_adr)
			`IK_ADDR_STATUS: rd_val = `IK_WB_DW'({i_singular, i_done, i_busy});
			`IK_ADDR_J00:    rd_val = sext(o_jac[0][0]);
			`IK_ADDR_J01:    rd_val = sext(o_jac[0][1]);
			`IK_ADDR_J10:    rd_val = sext(o_jac[1][0]);
			`IK_ADDR_J11:    rd_val = sext(o_jac[1][1]);
			`IK_ADDR_E0:     rd_val = sext(o_err0);
			`IK_ADDR_E1:     rd_val = sext(o_err1);
			`IK_ADDR_LAMBDA: rd_val = sext(o_lambda);
			`IK_ADDR_DELTA0: rd_val = sext(i_delta0);
			`IK_ADDR_DELTA1: rd_val = sext(i_delta1);
			default:         rd_val = '0;
		endcase
	end

	// read data lines up with the ack
	always_ff @(posedge i) begin
		o_wb_dat <= rd_val;
	end

endmodule

// ==== source/mat_mult_2x2.sv ====
// ======================================
// two-stage 2x2 fixed-point multiplier
// ======================================
`timescale 1ns/1ps

module mat_mult_2x2 (
	input  logic          i,
	input  logic          i_reset,
	input  logic          i_valid,
	input  ik_pkg::mat2_t i_a,
	input  ik_pkg::mat2_t i_b,
	output logic          o_valid,
	output ik_pkg::mat2_t o_result
);
	import ik_pkg::*;

	// products indexed [row][col][k]
	fixed_t prod [2][2][2];
	logic   valid_d;

	// stage 1 products, stage 2 sums
	always_ff @(posedge i) begin
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				for (int k = 0; k < 2; k++) begin
					prod[r][c][k] <= fix_mul(i_a[r][k], i_b[k][c]);
				end
				o_result[r][c] <= prod[r][c][0] + prod[r][c][1];
			end
		end
	end

	// valid follows the data through both stages
	always_ff @(posedge i) begin
		if (i_reset) begin
			valid_d <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			valid_d <= i_valid;
			o_valid <= valid_d;
		end
	end

endmodule

// ==== source/fixed_divider.sv ====
// ======================================
// serial restoring signed divider
// ======================================
`timescale 1ns/1ps
`include "ik_defines.svh"

module fixed_divider (
	input  logic                           i,
	input  logic                           i_reset,
	input  logic                           i_start,
	input  logic signed [2*`IK_DATA_W-1:0] i_dividend,
	input  ik_pkg::fixed_t                 i_divisor,
	output logic                           o_done,
	output ik_pkg::fixed_t                 o_quotient
);

	logic [2*`IK_DATA_W-1:0] quo;
	logic [2*`IK_DATA_W-1:0] quo_next;
	logic [`IK_DATA_W-1:0]   rem;
	logic [`IK_DATA_W-1:0]   rem_next;
	logic [`IK_DATA_W-1:0]   dvs;
	logic [`IK_DATA_W:0]     shifted;
	logic [4:0]              count;
	logic                    busy;
	logic                    neg;

	// one quotient bit per cycle
	always_comb begin
		shifted = {rem, quo[2*`IK_DATA_W-1]};
		if (shifted >= {1'b0, dvs}) begin
			rem_next = `IK_DATA_W'(shifted - {1'b0, dvs});
			quo_next = {quo[2*`IK_DATA_W-2:0], 1'b1};
		end else begin
			rem_next = shifted[`IK_DATA_W-1:0];
			quo_next = {quo[2*`IK_DATA_W-2:0], 1'b0};
		end
	end

	always_ff @(posedge i) begin
		if (i_reset) begin
			busy <= 1'b0;
			count <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 5'd1;
				if (count == 5'd31) begin
					busy <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	// magnitudes in and the sign applied on the last bit
	always_ff @(posedge i) begin
		if (i_start) begin
			quo <= i_dividend[2*`IK_DATA_W-1] ? -i_dividend : i_dividend;
			dvs <= i_divisor[`IK_DATA_W-1] ? -i_divisor : i_divisor;
			neg <= i_dividend[2*`IK_DATA_W-1] ^ i_divisor[`IK_DATA_W-1];
			rem <= '0;
		end else if (busy) begin
			quo <= quo_next;
			rem <= rem_next;
			if (count == 5'd31) begin
				o_quotient <= neg ? -quo_next[`IK_DATA_W-1:0] : quo_next[`IK_DATA_W-1:0];
			end
		end
	end

endmodule

// ==== source/inverse_2x2.sv ====
// ======================================
// 2x2 adjugate and determinant reciprocal
// ======================================
`timescale 1ns/1ps
`include "ik_defines.svh"

module inverse_2x2 (
	input  logic           i,
	input  logic           i_reset,
	input  logic           i_start,
	input  ik_pkg::mat2_t  i_matrix,
	output logic           o_ready,
	output logic           o_singular,
	output ik_pkg::mat2_t  o_adj,
	output ik_pkg::fixed_t o_recip
);
	import ik_pkg::*;

	// 1.0 squared, so the quotient keeps 8 fraction bits
	localparam logic signed [2*`IK_DATA_W-1:0] RECIP_ONE = 1 << (2 * `IK_FRAC_W);

	fixed_t det;
	logic   det_pending;
	logic   zero_ready;
	logic   div_start;
	logic   div_done;

	// determinant from two local multipliers, adjugate alongside
	always_ff @(posedge i) begin
		if (i_start) begin
			det <= fix_mul(i_matrix[0][0], i_matrix[1][1]) -
				fix_mul(i_matrix[0][1], i_matrix[1][0]);
			o_adj[0][0] <= i_matrix[1][1];
			o_adj[0][1] <= -i_matrix[0][1];
			o_adj[1][0] <= -i_matrix[1][0];
			o_adj[1][1] <= i_matrix[0][0];
		end
	end

	always_ff @(posedge i) begin
		if (i_reset) begin
			det_pending <= 1'b0;
			zero_ready <= 1'b0;
			o_singular <= 1'b0;
		end else begin
			det_pending <= i_start;
			zero_ready <= 1'b0;
			if (i_start) begin
				o_singular <= 1'b0;
			end else if (det_pending && det == '0) begin
				// no divide on a zero determinant
				zero_ready <= 1'b1;
				o_singular <= 1'b1;
			end
		end
	end

	assign div_start = det_pending && (det != '0);

	fixed_divider u_divider (
		.i          (i),
		.i_reset    (i_reset),
		.i_start    (div_start),
		.i_dividend (RECIP_ONE),
		.i_divisor  (det),
		.o_done     (div_done),
		.o_quotient (o_recip)
	);

	assign o_ready = zero_ready | div_done;

endmodule

// ==== source/ik_dls_step.sv ====
// ======================================
// step schedule and multiplier routing
// ======================================
`timescale 1ns/1ps

module ik_dls_step (
	input  logic           i,
	input  logic           i_reset,
	input  logic           i_start,
	input  ik_pkg::mat2_t  i_jac,
	input  ik_pkg::fixed_t i_err0,
	input  ik_pkg::fixed_t i_err1,
	input  ik_pkg::fixed_t i_lambda,
	input  logic           i_inv_ready,
	input  logic           i_inv_singular,
	input  ik_pkg::mat2_t  i_adj,
	input  ik_pkg::fixed_t i_recip,
	input  ik_pkg::mat2_t  i_mm_result,
	input  logic           i_mm_valid,
	output logic           o_inv_start,
	output ik_pkg::mat2_t  o_damped,
	output ik_pkg::mat2_t  o_mm_a,
	output ik_pkg::mat2_t  o_mm_b,
	output logic           o_mm_valid,
	output logic           o_busy,
	output logic           o_done,
	output logic           o_singular,
	output ik_pkg::fixed_t o_delta0,
	output ik_pkg::fixed_t o_delta1
);
	import ik_pkg::*;

	step_state_t state;
	mat2_t       jac_r;
	fixed_t      err0_r;
	fixed_t      err1_r;
	fixed_t      lambda_r;
	// holds damped matrix, then inverse, then Jt * inverse
	mat2_t       work_r;

	function automatic mat2_t transpose(input mat2_t m);
		mat2_t t;
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				t[r][c] = m[c][r];
			end
		end
		return t;
	endfunction

	assign o_damped = work_r;
	assign o_busy = (state != ST_IDLE) && (state != ST_DONE);

	// operand routing by phase, J * Jt otherwise
	always_comb begin
		o_mm_a = jac_r;
		o_mm_b = transpose(jac_r);
		case (state)
			ST_SCALE: begin
				// adjugate times recip on the diagonal
				o_mm_a = i_adj;
				o_mm_b = '0;
				o_mm_b[0][0] = i_recip;
				o_mm_b[1][1] = i_recip;
			end
			ST_JT_INV: begin
				o_mm_a = transpose(jac_r);
				o_mm_b = work_r;
			end
			ST_APPLY: begin
				o_mm_a = work_r;
				o_mm_b[0][0] = err0_r;
				o_mm_b[0][1] = err0_r;
				o_mm_b[1][0] = err1_r;
				o_mm_b[1][1] = err1_r;
			end
			default: ;
		endcase
	end

	always_ff @(posedge i) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_mm_valid <= 1'b0;
			o_inv_start <= 1'b0;
			o_done <= 1'b0;
			o_singular <= 1'b0;
			o_delta0 <= '0;
			o_delta1 <= '0;
		end else begin
			o_mm_valid <= 1'b0;
			o_inv_start <= 1'b0;
			case (state)
				ST_IDLE, ST_DONE: begin
					if (i_start) begin
						state <= ST_JJT;
						o_mm_valid <= 1'b1;
						o_done <= 1'b0;
						o_singular <= 1'b0;
					end
				end
				ST_JJT: begin
					if (i_mm_valid) begin
						state <= ST_INV;
						o_inv_start <= 1'b1;
					end
				end
				ST_INV: begin
					if (i_inv_ready && i_inv_singular) begin
						o_delta0 <= '0;
						o_delta1 <= '0;
						o_singular <= 1'b1;
						o_done <= 1'b1;
						state <= ST_DONE;
					end else if (i_inv_ready) begin
						state <= ST_SCALE;
						o_mm_valid <= 1'b1;
					end
				end
				ST_SCALE: begin
					if (i_mm_valid) begin
						state <= ST_JT_INV;
						o_mm_valid <= 1'b1;
					end
				end
				ST_JT_INV: begin
					if (i_mm_valid) begin
						state <= ST_APPLY;
						o_mm_valid <= 1'b1;
					end
				end
				ST_APPLY: begin
					if (i_mm_valid) begin
						// column 0 of M * [e e]
						o_delta0 <= i_mm_result[0][0];
						o_delta1 <= i_mm_result[1][0];
						o_done <= 1'b1;
						state <= ST_DONE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// operands latched on an accepted start
	always_ff @(posedge i) begin
		if (i_start && !o_busy) begin
			jac_r <= i_jac;
			err0_r <= i_err0;
			err1_r <= i_err1;
			lambda_r <= i_lambda;
		end
		if (i_mm_valid) begin
			case (state)
				ST_JJT: begin
					work_r <= i_mm_result;
					work_r[0][0] <= i_mm_result[0][0] + lambda_r;
					work_r[1][1] <= i_mm_result[1][1] + lambda_r;
				end
				ST_SCALE, ST_JT_INV: work_r <= i_mm_result;
				default: ;
			endcase
		end
	end

endmodule

// ==== source/ik_top.sv ====
// ======================================
// ik step engine behind a wishbone slave
// ======================================
`timescale 1ns/1ps
`include "ik_defines.svh"

module ik_top (
	input  logic                 i,
	input  logic                 i_reset,
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  logic [`IK_WB_AW-1:0] i_wb_adr,
	input  logic [`IK_WB_DW-1:0] i_wb_dat,
	output logic [`IK_WB_DW-1:0] o_wb_dat,
	output logic                 o_wb_ack,
	output logic                 o_irq
);
	import ik_pkg::*;

	// register slave to step engine
	logic   start, busy, done, singular;
	mat2_t  jac;
	fixed_t err0, err1, lambda, delta0, delta1;

	// step engine to inverse
	logic   inv_start, inv_ready, inv_singular;
	mat2_t  damped, adj;
	fixed_t recip;

	// shared multiplier
	logic   mm_in_valid, mm_out_valid;
	mat2_t  mm_a, mm_b, mm_result;

	wb_ik_regs u_regs (
		.i          (i),
		.i_reset    (i_reset),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_adr   (i_wb_adr),
		.i_wb_dat   (i_wb_dat),
		.i_busy     (busy),
		.i_done     (done),
		.i_singular (singular),
		.i_delta0   (delta0),
		.i_delta1   (delta1),
		.o_wb_dat   (o_wb_dat),
		.o_wb_ack   (o_wb_ack),
		.o_start    (start),
		.o_jac      (jac),
		.o_err0     (err0),
		.o_err1     (err1),
		.o_lambda   (lambda),
		.o_irq      (o_irq)
	);

	ik_dls_step u_step (
		.i              (i),
		.i_reset        (i_reset),
		.i_start        (start),
		.i_jac          (jac),
		.i_err0         (err0),
		.i_err1         (err1),
		.i_lambda       (lambda),
		.i_inv_ready    (inv_ready),
		.i_inv_singular (inv_singular),
		.i_adj          (adj),
		.i_recip        (recip),
		.i_mm_result    (mm_result),
		.i_mm_valid     (mm_out_valid),
		.o_inv_start    (inv_start),
		.o_damped       (damped),
		.o_mm_a         (mm_a),
		.o_mm_b         (mm_b),
		.o_mm_valid     (mm_in_valid),
		.o_busy         (busy),
		.o_done         (done),
		.o_singular     (singular),
		.o_delta0       (delta0),
		.o_delta1       (delta1)
	);

	inverse_2x2 u_inverse (
		.i          (i),
		.i_reset    (i_reset),
		.i_start    (inv_start),
		.i_matrix   (damped),
		.o_ready    (inv_ready),
		.o_singular (inv_singular),
		.o_adj      (adj),
		.o_recip    (recip)
	);

	mat_mult_2x2 u_mat_mult (
		.i        (i),
		.i_reset  (i_reset),
		.i_valid  (mm_in_valid),
		.i_a      (mm_a),
		.i_b      (mm_b),
		.o_valid  (mm_out_valid),
		.o_result (mm_result)
	);

endmodule

// ==== testbench/tb_ik_top.sv ====
// ======================================
// testbench for the ik step over wishbone
// ======================================
`timescale 1ns/1ps
`include "ik_defines.svh"

module tb_ik_top;
	import ik_pkg::*;

	localparam int ACK_LIMIT = 8;
	localparam int DONE_LIMIT = 500;
	localparam int POLL_LIMIT = 100;

	logic                 i;
	logic                 i_reset;
	logic                 i_wb_cyc;
	logic                 i_wb_stb;
	logic                 i_wb_we;
	logic [`IK_WB_AW-1:0] i_wb_adr;
	logic [`IK_WB_DW-1:0] i_wb_dat;
	logic [`IK_WB_DW-1:0] o_wb_dat;
	logic                 o_wb_ack;
	logic                 o_irq;

	logic [31:0] lfsr_state = 32'ha8a4_f32c;
	logic        ack_q = 1'b0;

	ik_top uut (
		.i        (i),
		.i_reset  (i_reset),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.o_irq    (o_irq)
	);

	always #5 i = ~i;

	task automatic abort_run();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, act);
		abort_run();
	endtask

	task automatic report_error(input string what);
		$display("error at %0t ns: %s", $time, what);
		abort_run();
	endtask

	// bus protocol watch on every edge
	always @(posedge i) begin
		if (!i_reset) begin
			assert (!(ack_q && o_wb_ack)) else report_error("ack stayed high for two cycles");
			assert (!(uut.busy && o_irq)) else report_error("busy and irq were high together");
		end
		ack_q <= o_wb_ack;
	end

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// value in -1.0 .. just under 1.0
	function automatic fixed_t rand_unit();
		logic [31:0] v;
		v = next_bits(9);
		return {{7{v[8]}}, v[8:0]};
	endfunction

	function automatic logic [31:0] sign_extend(input fixed_t v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
		logic signed [31:0] p;
		p = a * b;
		p = p >>> `IK_FRAC_W;
		return p[15:0];
	endfunction

	function automatic mat2_t matrix_product(input mat2_t a, input mat2_t b);
		mat2_t p;
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				p[r][c] = fixed_mul(a[r][0], b[0][c]) + fixed_mul(a[r][1], b[1][c]);
			end
		end
		return p;
	endfunction

	// expected delta from the fixed-point rules of the step
	task automatic model_step(input mat2_t jac, input fixed_t e0, input fixed_t e1,
			input fixed_t lam, output fixed_t d0, output fixed_t d1, output logic sing);
		mat2_t  jt, a, adj, diag, inv, m, b, prod;
		fixed_t det;
		fixed_t recip;
		int     quo;
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				jt[r][c] = jac[c][r];
			end
		end
		a = matrix_product(jac, jt);
		a[0][0] = a[0][0] + lam;
		a[1][1] = a[1][1] + lam;
		det = fixed_mul(a[0][0], a[1][1]) - fixed_mul(a[0][1], a[1][0]);
		sing = (det == 16'sd0);
		d0 = '0;
		d1 = '0;
		if (!sing) begin
			quo = 65536 / int'(det);
			recip = quo[15:0];
			adj[0][0] = a[1][1];
			adj[0][1] = -a[0][1];
			adj[1][0] = -a[1][0];
			adj[1][1] = a[0][0];
			diag = '0;
			diag[0][0] = recip;
			diag[1][1] = recip;
			inv = matrix_product(adj, diag);
			m = matrix_product(jt, inv);
			b[0][0] = e0;
			b[0][1] = e0;
			b[1][0] = e1;
			b[1][1] = e1;
			prod = matrix_product(m, b);
			d0 = prod[0][0];
			d1 = prod[1][0];
		end
	endtask

	// one transfer, ack expected on the second edge and gone on the third
	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		@(posedge i);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= we;
		i_wb_adr <= adr;
		i_wb_dat <= wdata;
		n = 0;
		do begin
			@(posedge i);
			n++;
		end while (!o_wb_ack && n < ACK_LIMIT);
		if (!o_wb_ack) begin
			report_error("no ack for a bus request");
		end
		assert (n == 2) else report_mismatch("ack latency", 2, n);
		rdata = o_wb_dat;
		i_wb_cyc <= 1'b0;
		i_wb_stb <= 1'b0;
		i_wb_we <= 1'b0;
		@(posedge i);
		assert (!o_wb_ack) else report_mismatch("o_wb_ack", 0, o_wb_ack);
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
		bus_cycle(1'b0, adr, 32'd0, data);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!o_irq && n < DONE_LIMIT) begin
			@(posedge i);
			n++;
		end
		if (!o_irq) begin
			report_error("step did not finish before the timeout");
		end
	endtask

	task automatic load_operands(input mat2_t jac, input fixed_t e0, input fixed_t e1,
			input fixed_t lam);
		wb_write(`IK_ADDR_J00, sign_extend(jac[0][0]));
		wb_write(`IK_ADDR_J01, sign_extend(jac[0][1]));
		wb_write(`IK_ADDR_J10, sign_extend(jac[1][0]));
		wb_write(`IK_ADDR_J11, sign_extend(jac[1][1]));
		wb_write(`IK_ADDR_E0, sign_extend(e0));
		wb_write(`IK_ADDR_E1, sign_extend(e1));
		wb_write(`IK_ADDR_LAMBDA, sign_extend(lam));
	endtask

	task automatic check_results(input fixed_t exp0, input fixed_t exp1, input logic exp_sing);
		logic [31:0] rd;
		logic [31:0] exp_status;
		exp_status = {29'd0, exp_sing, 2'b10};
		wb_read(`IK_ADDR_STATUS, rd);
		assert (rd == exp_status) else report_mismatch("status", exp_status, rd);
		assert (o_irq) else report_mismatch("o_irq", 1, o_irq);
		wb_read(`IK_ADDR_DELTA0, rd);
		assert (rd == sign_extend(exp0)) else report_mismatch("delta0", sign_extend(exp0), rd);
		wb_read(`IK_ADDR_DELTA1, rd);
		assert (rd == sign_extend(exp1)) else report_mismatch("delta1", sign_extend(exp1), rd);
	endtask

	task automatic run_case(input mat2_t jac, input fixed_t e0, input fixed_t e1,
			input fixed_t lam);
		fixed_t exp0, exp1;
		logic   exp_sing;
		load_operands(jac, e0, e1, lam);
		wb_write(`IK_ADDR_CTRL, 32'd1);
		wait_done();
		model_step(jac, e0, e1, lam, exp0, exp1, exp_sing);
		check_results(exp0, exp1, exp_sing);
	endtask

	// second start lands mid step, status polled until done
	task automatic run_overlapped_start(input mat2_t jac, input fixed_t e0, input fixed_t e1,
			input fixed_t lam);
		fixed_t      exp0, exp1;
		logic        exp_sing;
		logic [31:0] st;
		int          n;
		load_operands(jac, e0, e1, lam);
		wb_write(`IK_ADDR_CTRL, 32'd1);
		wb_read(`IK_ADDR_STATUS, st);
		assert (st == 32'd1) else report_mismatch("status while busy", 32'd1, st);
		wb_write(`IK_ADDR_J00, sign_extend(16'sh0040));
		wb_write(`IK_ADDR_CTRL, 32'd1);
		n = 0;
		wb_read(`IK_ADDR_STATUS, st);
		while (!st[1] && n < POLL_LIMIT) begin
			assert (st[0]) else report_mismatch("status busy", 1, st[0]);
			wb_read(`IK_ADDR_STATUS, st);
			n++;
		end
		if (!st[1]) begin
			report_error("status never showed done while polling");
		end
		model_step(jac, e0, e1, lam, exp0, exp1, exp_sing);
		check_results(exp0, exp1, exp_sing);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] vals [7];
		mat2_t       jac;
		fixed_t      e0, e1, lam;

		i = 1'b0;
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		repeat (3) @(posedge i);
		i_reset <= 1'b0;

		// idle state after reset
		@(posedge i);
		assert (!o_wb_ack) else report_mismatch("o_wb_ack", 0, o_wb_ack);
		assert (!o_irq) else report_mismatch("o_irq", 0, o_irq);
		wb_read(`IK_ADDR_STATUS, rd);
		assert (rd == 32'd0) else report_mismatch("status", 0, rd);

		// operand readback, addresses 2 to 8
		for (int k = 0; k < 7; k++) begin
			vals[k] = next_bits(16);
			wb_write(4'(k + 2), vals[k]);
		end
		for (int k = 0; k < 7; k++) begin
			wb_read(4'(k + 2), rd);
			assert (rd == sign_extend(vals[k][15:0]))
				else report_mismatch("operand readback", sign_extend(vals[k][15:0]), rd);
		end
		for (int k = 11; k < 16; k++) begin
			wb_read(4'(k), rd);
			assert (rd == 32'd0) else report_mismatch("unmapped read", 0, rd);
		end
		wb_read(`IK_ADDR_CTRL, rd);
		assert (rd == 32'd0) else report_mismatch("control read", 0, rd);

		// identity jacobian, no damping
		jac = '0;
		jac[0][0] = 16'sh0100;
		jac[1][1] = 16'sh0100;
		run_case(jac, 16'sh0180, 16'shff40, 16'sh0000);

		// diagonal jacobian with half damping
		jac = '0;
		jac[0][0] = 16'sh0200;
		jac[1][1] = 16'sh0080;
		run_case(jac, 16'sh0100, 16'sh0100, 16'sh0080);

		for (int n = 0; n < 20; n++) begin
			jac[0][0] = rand_unit();
			jac[0][1] = rand_unit();
			jac[1][0] = rand_unit();
			jac[1][1] = rand_unit();
			e0 = rand_unit();
			e1 = rand_unit();
			lam = fixed_t'(64 + (next_bits(8) % 193));
			run_case(jac, e0, e1, lam);
		end

		// singular case, then a normal step clears the flag
		jac = '0;
		run_case(jac, 16'sh0100, 16'sh0100, 16'sh0000);
		jac[0][0] = 16'sh0100;
		jac[1][1] = 16'sh0100;
		run_case(jac, 16'sh0020, 16'shffe0, 16'sh0000);

		jac[0][0] = 16'sh00c0;
		jac[0][1] = 16'shff80;
		jac[1][0] = 16'sh0040;
		jac[1][1] = 16'sh0100;
		run_overlapped_start(jac, 16'sh0080, 16'shff00, 16'sh0060);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+source
source/ik_pkg.sv
source/wb_ik_regs.sv
source/mat_mult_2x2.sv
source/fixed_divider.sv
source/inverse_2x2.sv
source/ik_dls_step.sv
source/ik_top.sv
testbench/tb_ik_top.sv

// ==== Bender.yml ====
package:
  name: ik_dls_step

sources:
  - include_dirs:
      - source
    files:
      - source/ik_pkg.sv
      - source/wb_ik_regs.sv
      - source/mat_mult_2x2.sv
      - source/fixed_divider.sv
      - source/inverse_2x2.sv
      - source/ik_dls_step.sv
      - source/ik_top.sv
      - target: test
        files:
          - testbench/tb_ik_top.sv
